/* Bender.yml */
package:
  name: rf_pg_bank

sources:
  - hdl/rf_pkg.sv
  - hdl/mem_reset_sync_scan.sv
  - hdl/rf_array_2p.sv
  - hdl/rf_pg_32x16.sv
  - hdl/rf_pgcb.sv
  - hdl/rf_pg_bank_top.sv
  - target: simulation
    files:
      - verification/rf_pg_bank_tb.sv

/* hdl/mem_reset_sync_scan.sv */
// Memory reset synchronizer, two flops deep, with a scan reset-bypass select
`timescale 1ns/1ps
`default_nettype none

module mem_reset_sync_scan (
     input  logic clk
    ,input  logic arst_n

    // Scan reset bypass
    ,input  logic fscan_rstbypen
    ,input  logic fscan_byprst_b

    ,output logic rst_n_sync
);

    // Bit 1 is the synchronized reset, bit 0 the metastability stage
    logic [1:0] sync_q;

    // --------------------------------------------------
    // Synchronizer flops
    // --------------------------------------------------

    // Assertion is immediate through the async clear
    // Release ripples a one through both stages, so it lands two clk edges later
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sync_q <= 2'b00;
        end else begin
            sync_q <= {sync_q[0], 1'b1};
        end
    end

    // In scan reset-bypass mode the tester drives the reset directly,
    // so the flops are taken out of the path entirely
    assign rst_n_sync = fscan_rstbypen ? fscan_byprst_b : sync_q[1];

endmodule

`default_nettype wire

/* hdl/rf_array_2p.sv */
// Behavioral two-clock 32x16 register array with a registered read port and power-loss clear
`timescale 1ns/1ps
`default_nettype none

module rf_array_2p (
     input  logic             wclk
    ,input  logic             rclk
    ,input  logic             rst_n

    ,input  rf_pkg::rf_wr_t   wr
    ,input  rf_pkg::rf_rd_t   rd

    // High while the power switch feeding this array is closed
    ,input  logic             powered

    ,output rf_pkg::rf_data_t rdata
);

    import rf_pkg::*;

    // Storage words, no reset, contents only defined after a write or a power loss
    rf_data_t mem [RF_DEPTH];

    // Read data register on the rclk side
    rf_data_t rdata_q;

    // --------------------------------------------------
    // Write side (wclk)
    // --------------------------------------------------

    // Losing power wipes every word, which stands in for the lost
    // contents of the real macro
    // The powered level comes from the rclk domain but holds for many
    // cycles on either side of a sequence, so sampling it here is safe
    always_ff @(posedge wclk) begin
        if (!powered) begin
            for (int i = 0; i < RF_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr.we) begin
            mem[wr.waddr] <= wr.wdata;
        end
    end

    // --------------------------------------------------
    // Read side (rclk)
    // --------------------------------------------------

    // The register only loads on re, otherwise it holds the last word read
    // An unpowered array reads back as zero, as the output latches would lose state too
    always_ff @(posedge rclk or negedge rst_n) begin
        if (!rst_n) begin
            rdata_q <= '0;
        end else if (!powered) begin
            rdata_q <= '0;
        end else if (rd.re) begin
            rdata_q <= mem[rd.raddr];
        end
    end

    assign rdata = rdata_q;

    // A read request reaching the array with its switches open points at a
    // broken sequence somewhere upstream, since the controller keeps
    // traffic isolated until the chain has fully closed again
    a_no_read_unpowered: assert property (
        @(posedge rclk) disable iff (!rst_n)
        !powered |-> !rd.re
    ) else $error("rf_array_2p: read request while the array is unpowered");

endmodule

`default_nettype wire

/* hdl/rf_pg_32x16.sv */
// Power-gated 32x16 register-file wrapper with reset sync, switch chain and output isolation
`timescale 1ns/1ps
`default_nettype none

module rf_pg_32x16 (
     input  logic             wclk
    ,input  logic             rclk
    ,input  logic             arst_n

    ,input  rf_pkg::rf_wr_t   wr
    ,input  rf_pkg::rf_rd_t   rd
    ,output rf_pkg::rf_data_t rdata

    // Power interface, enable levels are active low (1 means switches open)
    ,input  logic             pgcb_isol_en
    ,input  logic             pwr_enable_b_in
    ,output logic             pwr_enable_b_out

    // Scan reset bypass
    ,input  logic             fscan_rstbypen
    ,input  logic             fscan_byprst_b
);

    import rf_pkg::*;

    logic                       rst_n_sync;
    logic [PWR_CHAIN_DELAY-1:0] sw_chain_q;
    logic                       powered;
    rf_wr_t                     wr_gated;
    rf_data_t                   rdata_arr;

    // Read-domain reset for the switch chain and the array read register
    mem_reset_sync_scan rst_sync_i (
         .clk            (rclk)
        ,.arst_n         (arst_n)
        ,.fscan_rstbypen (fscan_rstbypen)
        ,.fscan_byprst_b (fscan_byprst_b)
        ,.rst_n_sync     (rst_n_sync)
    );

    // --------------------------------------------------
    // Power switch chain
    // --------------------------------------------------

    // Each stage stands for one segment of the switch daisy chain;
    // the last stage is what the next wrapper in line sees
    always_ff @(posedge rclk or negedge rst_n_sync) begin
        if (!rst_n_sync) begin
            sw_chain_q <= '0;
        end else begin
            sw_chain_q <= {sw_chain_q[PWR_CHAIN_DELAY-2:0], pwr_enable_b_in};
        end
    end

    assign pwr_enable_b_out = sw_chain_q[PWR_CHAIN_DELAY-1];

    // The array only counts as powered once the whole local chain has closed
    assign powered = ~pwr_enable_b_out;

    // Isolation blocks the write strobe, address and data pass unchanged
    always_comb begin
        wr_gated    = wr;
        wr_gated.we = wr.we & ~pgcb_isol_en;
    end

    rf_array_2p array_i (
         .wclk    (wclk)
        ,.rclk    (rclk)
        ,.rst_n   (rst_n_sync)
        ,.wr      (wr_gated)
        ,.rd      (rd)
        ,.powered (powered)
        ,.rdata   (rdata_arr)
    );

    // Output clamp keeps floating array outputs away from the always-on logic
    assign rdata = pgcb_isol_en ? '0 : rdata_arr;

    // Whoever drives the write port must stop before isolation is raised;
    // the gate above only hides the violation
    a_no_write_isolated: assert property (
        @(posedge wclk) disable iff (!arst_n)
        pgcb_isol_en |-> !wr.we
    ) else $error("rf_pg_32x16: write strobe while the store is isolated");

endmodule

`default_nettype wire

/* hdl/rf_pg_bank_top.sv */
// Register-file bank with two power-gated stores on one switch chain and their controller
`timescale 1ns/1ps
`default_nettype none

module rf_pg_bank_top (
     input  logic             wclk
    ,input  logic             rclk
    ,input  logic             arst_n
    ,input  logic             fscan_rstbypen
    ,input  logic             fscan_byprst_b

    // Power request and status
    ,input  logic             sleep_req
    ,output logic             pwr_ok

    // Write-side store
    ,input  rf_pkg::rf_wr_t   wr0
    ,input  rf_pkg::rf_rd_t   rd0
    ,output rf_pkg::rf_data_t rdata0

    // Read-side store
    ,input  rf_pkg::rf_wr_t   wr1
    ,input  rf_pkg::rf_rd_t   rd1
    ,output rf_pkg::rf_data_t rdata1
);

    logic pgcb_isol_en;
    logic pwr_enable_b;
    // Enable between the two stores, then back to the controller
    logic chain_mid_b;
    logic chain_ack_b;

    // --------------------------------------------------
    // Controller and the two chained stores
    // --------------------------------------------------

    rf_pgcb pgcb_i (
         .rclk           (rclk)
        ,.arst_n         (arst_n)
        ,.fscan_rstbypen (fscan_rstbypen)
        ,.fscan_byprst_b (fscan_byprst_b)
        ,.sleep_req      (sleep_req)
        ,.chain_ack_b    (chain_ack_b)
        ,.pgcb_isol_en   (pgcb_isol_en)
        ,.pwr_enable_b   (pwr_enable_b)
        ,.pwr_ok         (pwr_ok)
    );

    rf_pg_32x16 rf0_i (
         .wclk             (wclk)
        ,.rclk             (rclk)
        ,.arst_n           (arst_n)
        ,.wr               (wr0)
        ,.rd               (rd0)
        ,.rdata            (rdata0)
        ,.pgcb_isol_en     (pgcb_isol_en)
        ,.pwr_enable_b_in  (pwr_enable_b)
        ,.pwr_enable_b_out (chain_mid_b)
        ,.fscan_rstbypen   (fscan_rstbypen)
        ,.fscan_byprst_b   (fscan_byprst_b)
    );

    rf_pg_32x16 rf1_i (
         .wclk             (wclk)
        ,.rclk             (rclk)
        ,.arst_n           (arst_n)
        ,.wr               (wr1)
        ,.rd               (rd1)
        ,.rdata            (rdata1)
        ,.pgcb_isol_en     (pgcb_isol_en)
        ,.pwr_enable_b_in  (chain_mid_b)
        ,.pwr_enable_b_out (chain_ack_b)
        ,.fscan_rstbypen   (fscan_rstbypen)
        ,.fscan_byprst_b   (fscan_byprst_b)
    );

endmodule

`default_nettype wire

/* hdl/rf_pgcb.sv */
// Power-gate controller that sequences isolation and switch enable for a store chain
`timescale 1ns/1ps
`default_nettype none

module rf_pgcb (
     input  logic rclk
    ,input  logic arst_n
    ,input  logic fscan_rstbypen
    ,input  logic fscan_byprst_b

    // Request level, high asks for power-down
    ,input  logic sleep_req
    // Switch enable returned from the far end of the chain
    ,input  logic chain_ack_b

    ,output logic pgcb_isol_en
    ,output logic pwr_enable_b
    ,output logic pwr_ok
);

    import rf_pkg::*;

    logic      rst_n_sync;
    pg_state_t state_q;
    pg_state_t state_d;

    mem_reset_sync_scan rst_sync_i (
         .clk            (rclk)
        ,.arst_n         (arst_n)
        ,.fscan_rstbypen (fscan_rstbypen)
        ,.fscan_byprst_b (fscan_byprst_b)
        ,.rst_n_sync     (rst_n_sync)
    );

    // --------------------------------------------------
    // Sequencer FSM
    // --------------------------------------------------

    // sleep_req is only looked at in the two resting states; a change in the
    // middle of a sequence waits until that sequence has finished
    always_comb begin
        state_d = state_q;
        case (state_q)
            PG_ON:         if (sleep_req)    state_d = PG_ISOLATE;
            PG_ISOLATE:                      state_d = PG_SWITCH_OFF;
            PG_SWITCH_OFF: if (chain_ack_b)  state_d = PG_OFF;
            PG_OFF:        if (!sleep_req)   state_d = PG_SWITCH_ON;
            PG_SWITCH_ON:  if (!chain_ack_b) state_d = PG_DEISOLATE;
            PG_DEISOLATE:                    state_d = PG_ON;
            default:                         state_d = PG_ON;
        endcase
    end

    always_ff @(posedge rclk or negedge rst_n_sync) begin
        if (!rst_n_sync) begin
            state_q <= PG_ON;
        end else begin
            state_q <= state_d;
        end
    end

    // Isolation covers every state but PG_ON, so it is up before the switches open
    // and stays up until one cycle after the chain reports closed
    assign pgcb_isol_en = (state_q != PG_ON);
    assign pwr_enable_b = (state_q == PG_SWITCH_OFF) || (state_q == PG_OFF);
    assign pwr_ok       = (state_q == PG_ON);

    // Opening the switches must come at least one cycle after isolation went up
    a_isol_before_switch_off: assert property (
        @(posedge rclk) disable iff (!rst_n_sync)
        $rose(pwr_enable_b) |-> $past(pgcb_isol_en)
    ) else $error("rf_pgcb: switch-off without prior isolation");

endmodule

`default_nettype wire

/* hdl/rf_pkg.sv */
// Register-file power-gating package with word widths, port structs, power states and timing
`default_nettype none

package rf_pkg;

    // --------------------------------------------------
    // Array geometry
    // --------------------------------------------------

    // Number of words held by one store
    localparam int RF_DEPTH = 32;

    // Read-clock cycles one wrapper's switch chain needs to pass an enable change
    localparam int PWR_CHAIN_DELAY = 4;

    // Word address and data word
    typedef logic [4:0]  rf_addr_t;
    typedef logic [15:0] rf_data_t;

    // --------------------------------------------------
    // Port bundles
    // --------------------------------------------------

    // Write port, sampled on wclk
    typedef struct packed {
        logic     we;
        rf_addr_t waddr;
        rf_data_t wdata;
    } rf_wr_t;

    // Read port, sampled on rclk
    typedef struct packed {
        logic     re;
        rf_addr_t raddr;
    } rf_rd_t;

    // Power-gate controller states, in sequence order
    typedef enum logic [2:0] {
        PG_ON,
        PG_ISOLATE,
        PG_SWITCH_OFF,
        PG_OFF,
        PG_SWITCH_ON,
        PG_DEISOLATE
    } pg_state_t;

endpackage

`default_nettype wire

/* list.f */
hdl/rf_pkg.sv
hdl/mem_reset_sync_scan.sv
hdl/rf_array_2p.sv
hdl/rf_pg_32x16.sv
hdl/rf_pgcb.sv
hdl/rf_pg_bank_top.sv
verification/rf_pg_bank_tb.sv

/* verification/rf_pg_bank_tb.sv */
// Directed testbench for the power-gated register-file bank with a word-level reference model
`timescale 1ns/1ps
`default_nettype none

module rf_pg_bank_tb;

    import rf_pkg::*;

    logic     wclk;
    logic     rclk;
    logic     arst_n;
    logic     fscan_rstbypen;
    logic     fscan_byprst_b;
    logic     sleep_req;
    logic     pwr_ok;
    rf_wr_t   wr0;
    rf_wr_t   wr1;
    rf_rd_t   rd0;
    rf_rd_t   rd1;
    rf_data_t rdata0;
    rf_data_t rdata1;

    // Reference contents of both stores
    rf_data_t model0 [RF_DEPTH];
    rf_data_t model1 [RF_DEPTH];

    int seed = 32'hf3edc121;
    int errors = 0;
    int checks = 0;
    int cycles = 0;

    rf_pg_bank_top dut_i (
         .wclk           (wclk)
        ,.rclk           (rclk)
        ,.arst_n         (arst_n)
        ,.fscan_rstbypen (fscan_rstbypen)
        ,.fscan_byprst_b (fscan_byprst_b)
        ,.sleep_req      (sleep_req)
        ,.pwr_ok         (pwr_ok)
        ,.wr0            (wr0)
        ,.rd0            (rd0)
        ,.rdata0         (rdata0)
        ,.wr1            (wr1)
        ,.rd1            (rd1)
        ,.rdata1         (rdata1)
    );

    // --------------------------------------------------
    // Clocks and run limit
    // --------------------------------------------------

    initial begin
        wclk = 1'b0;
        forever #10 wclk = ~wclk;
    end

    // The read clock trails the write clock by 5 ns
    initial begin
        rclk = 1'b0;
        #5;
        forever #10 rclk = ~rclk;
    end

    // 44 writes at two cycles and 76 reads at three cycles, with the reset checks
    // and both power sequences, come to under 400 cycles so 2000 leaves ample margin
    always @(posedge rclk) begin
        cycles++;
        if (cycles >= 2000) begin
            $display("Timeout: the run did not finish within 2000 rclk cycles");
            $display("Result: FAILED");
            $finish;
        end
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------

    task automatic check(input string name, input rf_data_t expected, input rf_data_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Both write strobes go up for one rclk cycle, which spans exactly one wclk edge
    task automatic write_both(input rf_addr_t addr, input rf_data_t d0, input rf_data_t d1);
        @(posedge rclk);
        #2;
        wr0.we = 1'b1;
        wr0.waddr = addr;
        wr0.wdata = d0;
        wr1.we = 1'b1;
        wr1.waddr = addr;
        wr1.wdata = d1;
        model0[addr] = d0;
        model1[addr] = d1;
        @(posedge rclk);
        #2;
        wr0.we = 1'b0;
        wr1.we = 1'b0;
    endtask

    // Read both stores at one address, then confirm the data stays put with re low
    task automatic read_check(input string name, input rf_addr_t addr);
        rf_data_t got0;
        rf_data_t got1;
        @(posedge rclk);
        #2;
        rd0.re = 1'b1;
        rd0.raddr = addr;
        rd1.re = 1'b1;
        rd1.raddr = addr;
        @(posedge rclk);
        #2;
        rd0.re = 1'b0;
        rd1.re = 1'b0;
        rd0.raddr = addr + 5'd1;
        rd1.raddr = addr + 5'd1;
        got0 = rdata0;
        got1 = rdata1;
        check({name, " rdata0"}, model0[addr], got0);
        check({name, " rdata1"}, model1[addr], got1);
        @(posedge rclk);
        #2;
        check({name, " rdata0 hold"}, model0[addr], rdata0);
        check({name, " rdata1 hold"}, model1[addr], rdata1);
    endtask

    task automatic wait_pwr_ok(input string name, input logic level);
        int n;
        n = 0;
        while (pwr_ok !== level && n < 30) begin
            @(posedge rclk);
            #2;
            n++;
        end
        if (pwr_ok !== level) begin
            errors++;
            $display("Test %s: pwr_ok did not reach %b within 30 cycles", name, level);
        end
    endtask

    // --------------------------------------------------
    // Tests
    // --------------------------------------------------

    // Array words are undefined after reset, so only the read registers are looked at
    task automatic test_reset_state();
        check("reset pwr_ok", 16'd1, {15'd0, pwr_ok});
        for (int i = 0; i < 8; i++) begin
            @(posedge rclk);
            #2;
            rd0.raddr = $random(seed);
            rd1.raddr = $random(seed);
            check("reset rdata0", 16'h0000, rdata0);
            check("reset rdata1", 16'h0000, rdata1);
        end
    endtask

    task automatic test_fill_readback();
        for (int a = 0; a < RF_DEPTH; a++) begin
            write_both(a, $random(seed), $random(seed));
        end
        for (int a = 0; a < RF_DEPTH; a++) begin
            read_check("fill readback", a);
        end
    endtask

    task automatic test_independent();
        rf_data_t d;
        for (int i = 0; i < 4; i++) begin
            d = $random(seed);
            write_both(i * 7, d, ~d);
        end
        for (int i = 0; i < 4; i++) begin
            read_check("independent", i * 7);
        end
    endtask

    // The clamp must hold both outputs at zero for the whole sleep period
    task automatic test_sleep();
        @(posedge rclk);
        #2;
        sleep_req = 1'b1;
        wait_pwr_ok("sleep", 1'b0);
        for (int i = 0; i < 20; i++) begin
            check("sleep rdata0", 16'h0000, rdata0);
            check("sleep rdata1", 16'h0000, rdata1);
            @(posedge rclk);
            #2;
        end
    endtask

    task automatic test_wake();
        sleep_req = 1'b0;
        wait_pwr_ok("wake", 1'b1);
        // Power loss wiped both stores
        for (int a = 0; a < RF_DEPTH; a++) begin
            model0[a] = '0;
            model1[a] = '0;
        end
        for (int a = 0; a < RF_DEPTH; a++) begin
            read_check("wake cleared", a);
        end
        for (int a = 0; a < 8; a++) begin
            write_both(a * 3, $random(seed), $random(seed));
        end
        for (int a = 0; a < 8; a++) begin
            read_check("wake rewrite", a * 3);
        end
    endtask

    initial begin
        arst_n = 1'b0;
        fscan_rstbypen = 1'b0;
        fscan_byprst_b = 1'b1;
        sleep_req = 1'b0;
        wr0 = '0;
        wr1 = '0;
        rd0 = '0;
        rd1 = '0;
        repeat (2) @(posedge rclk);
        #2;
        arst_n = 1'b1;
        // Let the two-flop reset synchronizers release
        repeat (3) @(posedge rclk);
        #2;
        test_reset_state();
        test_fill_readback();
        test_independent();
        test_sleep();
        test_wake();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
